// File: bench/fp_pend_chk.sv
`timescale 1ns/10ps
`include "fp_pend_cfg.svh"

module fp_pend_chk (
    input logic              clk_i,
    input logic              rstn_i,
    input logic              flush_i,
    input fp_ctrl_pkg::ptr_t tail_i,       // Next free entry
    input fp_ctrl_pkg::num_t num_i,        // Occupancy
    input logic              head_valid_i
);
    import fp_ctrl_pkg::*;

    localparam num_t MAX_NUM = num_t'(`FP_PEND_ENTRIES);

    occ_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i) num_i <= MAX_NUM)
        else $error("Occupancy %0d above entry count", num_i);

    // Tail holds while the queue is full
    no_write_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (num_i == MAX_NUM && !flush_i) |=> $stable(tail_i))
        else $error("Entry written while queue full");

    head_after_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !head_valid_i)
        else $error("Head valid in the cycle after flush");

    head_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !head_valid_i)
        else $error("Head valid during reset");

endmodule

bind fp_pend_queue fp_pend_chk chk0 (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .flush_i      (flush_i),
    .tail_i       (tail),
    .num_i        (num),
    .head_valid_i (head_valid_o)
);

// File: bench/fp_pend_tb.sv
`timescale 1ns/10ps
`include "fp_pend_cfg.svh"

module fp_pend_tb;
    import fp_types_pkg::*;
    import fp_ctrl_pkg::*;

    localparam int TBL_LEN = 20;
    // Four table passes at slow latency, plus margin
    localparam int MAX_CYCLES = 4 * TBL_LEN * (`FP_SLOW_STAGES + 2) + 200;
    localparam fflags_t NV = 5'h10;

    typedef struct packed {
        fp_op_e  op;
        fp32_t   a;
        fp32_t   b;
        fp32_t   res; // Expected result
        fflags_t flg; // Expected flags
    } row_t;

    row_t tbl [TBL_LEN] = '{
        '{OP_FMIN,   32'h00000000, 32'h80000000, 32'h80000000, 5'h00}, // -0 below +0
        '{OP_FSGNJ,  32'h3f800000, 32'hc0000000, 32'hbf800000, 5'h00},
        '{OP_FMAX,   32'h00000000, 32'h80000000, 32'h00000000, 5'h00},
        '{OP_FSGNJN, 32'h3f800000, 32'hc0000000, 32'h3f800000, 5'h00},
        '{OP_FMIN,   32'h7fc00000, 32'h3f800000, 32'h3f800000, 5'h00}, // Quiet NaN loses
        '{OP_FSGNJX, 32'hc0000000, 32'hc0000000, 32'h40000000, 5'h00},
        '{OP_FMAX,   32'h7f800001, 32'h3f800000, 32'h3f800000, NV},
        '{OP_FSGNJ,  32'h40490fdb, 32'h80000000, 32'hc0490fdb, 5'h00},
        '{OP_FMIN,   32'h7fc00000, 32'h7f800001, 32'h7fc00000, NV},    // Both NaN
        '{OP_FMAX,   32'h7fc00000, 32'hffc00001, 32'h7fc00000, 5'h00},
        '{OP_FSGNJX, 32'h3f800000, 32'h80000000, 32'hbf800000, 5'h00},
        '{OP_FMIN,   32'hc0000000, 32'hc1200000, 32'hc1200000, 5'h00},
        '{OP_FMAX,   32'hc0000000, 32'hc1200000, 32'hc0000000, 5'h00},
        '{OP_FSGNJN, 32'h7f800001, 32'h3f800000, 32'hff800001, 5'h00}, // No flag on NaN
        '{OP_FMAX,   32'h7f800000, 32'h40490fdb, 32'h7f800000, 5'h00},
        '{OP_FMIN,   32'hff800000, 32'h7f800001, 32'hff800000, NV},
        '{OP_FSGNJ,  32'h7fc00000, 32'h80000000, 32'hffc00000, 5'h00},
        '{OP_FMAX,   32'h3f800000, 32'hffc00001, 32'h3f800000, 5'h00},
        '{OP_FMIN,   32'h3f800000, 32'h3f800001, 32'h3f800000, 5'h00}, // One ulp apart
        '{OP_FSGNJX, 32'hc1200000, 32'h3f800000, 32'hc1200000, 5'h00}
    };

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic        flush_i;
    logic        in_valid_i;
    fp_op_e      in_op_i;
    fp32_t       in_a_i;
    fp32_t       in_b_i;
    logic        out_ready_i;
    logic        fflags_clr_i;
    logic        in_ready_o;
    tag_t        in_tag_o;
    logic        out_valid_o;
    tag_t        out_tag_o;
    fp32_t       out_data_o;
    fflags_t     out_flags_o;
    fflags_t     fflags_o;
    retire_cnt_t retired_o;

    // Reference model, oldest first
    tag_t    exp_tag_q [$];
    fp32_t   exp_res_q [$];
    fflags_t exp_flg_q [$];
    tag_t    next_tag    = '0;
    fflags_t exp_fflags  = '0;
    int      exp_retired = 0;

    int          cur_row  = 0;     // Row on the input bus
    int          err_cnt  = 0;
    int          err_mark = 0;
    int          test_cnt = 0;
    int          cycles   = 0;
    int          n_acc;
    logic        rdy_rand = 1'b0;  // Random or held-low out_ready
    logic [31:0] lfsr     = 32'hdd48e9d3;

    fp_pend_top dut0 (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    always @(posedge clk_i) begin
        if (rdy_rand) begin
            out_ready_i <= lfsr[0];
            lfsr = lfsr_step(lfsr); // One step per bit taken
        end else begin
            out_ready_i <= 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Handshakes resolve at the next rising edge
    always @(negedge clk_i) begin : monitor
        fflags_t ret_flg;
        ret_flg = '0;
        if (rstn_i) begin
            assert (fflags_o == exp_fflags && retired_o == retire_cnt_t'(exp_retired))
            else begin
                $display("Error: %0d ns: fflags %h retired %0d, expected %h %0d",
                         $time, fflags_o, retired_o, exp_fflags, exp_retired);
                err_cnt++;
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_tag_q.size() == 0) begin
                    $display("Result with tag %0d retired with nothing outstanding", out_tag_o);
                    err_cnt++;
                end else begin
                    assert (out_tag_o == exp_tag_q[0] && out_data_o == exp_res_q[0] &&
                            out_flags_o == exp_flg_q[0])
                    else begin
                        $display("Error: %0d ns: tag %0d data %h flags %h, expected %0d %h %h",
                                 $time, out_tag_o, out_data_o, out_flags_o,
                                 exp_tag_q[0], exp_res_q[0], exp_flg_q[0]);
                        err_cnt++;
                    end
                    ret_flg = exp_flg_q[0];
                    void'(exp_tag_q.pop_front());
                    void'(exp_res_q.pop_front());
                    void'(exp_flg_q.pop_front());
                end
                exp_retired++;
            end
            exp_fflags = (fflags_clr_i ? '0 : exp_fflags) | ret_flg;
            if (in_valid_i && in_ready_o) begin
                assert (in_tag_o == next_tag)
                else begin
                    $display("Error: %0d ns: issue tag %0d, expected %0d",
                             $time, in_tag_o, next_tag);
                    err_cnt++;
                end
                exp_tag_q.push_back(next_tag);
                exp_res_q.push_back(tbl[cur_row].res);
                exp_flg_q.push_back(tbl[cur_row].flg);
                next_tag++;
            end
            if (flush_i) begin
                exp_tag_q.delete();
                exp_res_q.delete();
                exp_flg_q.delete();
                next_tag = '0;
            end
        end
    end

    task automatic present_row(input int r);
        cur_row    = r;
        in_valid_i <= 1'b1;
        in_op_i    <= tbl[r].op;
        in_a_i     <= tbl[r].a;
        in_b_i     <= tbl[r].b;
    endtask

    // Called on a rising edge, returns on the accepting edge
    task automatic send_row(input int r);
        present_row(r);
        @(negedge clk_i);
        while (!in_ready_o)
            @(negedge clk_i);
        @(posedge clk_i);
    endtask

    // Called on a rising edge, returns on a falling edge once all retired
    task automatic drain();
        in_valid_i <= 1'b0;
        @(negedge clk_i);
        while (exp_tag_q.size() != 0 || out_valid_o)
            @(negedge clk_i);
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s finished with %0d errors", test_cnt, name, err_cnt - err_mark);
        test_cnt++;
        err_mark = err_cnt;
    endtask

    initial begin
        rstn_i       = 1'b0;
        flush_i      = 1'b0;
        in_valid_i   = 1'b0;
        in_op_i      = OP_FSGNJ;
        in_a_i       = '0;
        in_b_i       = '0;
        out_ready_i  = 1'b0;
        fflags_clr_i = 1'b0;

        @(negedge clk_i);
        assert (!in_ready_o && !out_valid_o)
        else begin
            $display("Error: %0d ns: handshake outputs high during reset", $time);
            err_cnt++;
        end
        @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        assert (in_ready_o && !out_valid_o && in_tag_o == '0 && fflags_o == '0 && retired_o == '0)
        else begin
            $display("Error: %0d ns: wrong state after reset", $time);
            err_cnt++;
        end
        end_test("reset");

        rdy_rand = 1'b1;
        @(posedge clk_i);
        for (int r = 0; r < TBL_LEN; r++)
            send_row(r);
        drain();
        assert (fflags_o[4])
        else begin
            $display("Error: %0d ns: NV not sticky after signaling NaN rows", $time);
            err_cnt++;
        end
        end_test("table");

        // Fill with the head held back
        rdy_rand = 1'b0;
        n_acc    = 0;
        repeat (2) @(posedge clk_i);
        for (int r = 0; r < TBL_LEN; r++) begin
            present_row(r);
            @(negedge clk_i);
            if (!in_ready_o)
                break;
            @(posedge clk_i);
            n_acc++;
        end
        repeat (2) @(negedge clk_i);
        assert (!in_ready_o && n_acc == `FP_PEND_ENTRIES)
        else begin
            $display("Error: %0d ns: %0d ops accepted before full, ready %b",
                     $time, n_acc, in_ready_o);
            err_cnt++;
        end
        rdy_rand = 1'b1;
        @(posedge clk_i);
        drain();
        end_test("back-pressure");

        rdy_rand = 1'b0;
        @(posedge clk_i);
        send_row(6);
        send_row(1);
        send_row(8);
        send_row(5);
        in_valid_i <= 1'b0;
        flush_i    <= 1'b1;  // Slow ops still in the lane
        @(posedge clk_i);
        flush_i    <= 1'b0;
        @(negedge clk_i);
        assert (!out_valid_o && in_tag_o == '0)
        else begin
            $display("Error: %0d ns: after flush out_valid %b tag %0d",
                     $time, out_valid_o, in_tag_o);
            err_cnt++;
        end
        rdy_rand = 1'b1;
        @(posedge clk_i);
        send_row(12);
        send_row(3);
        drain();
        end_test("flush");

        @(posedge clk_i);
        fflags_clr_i <= 1'b1;
        @(posedge clk_i);
        fflags_clr_i <= 1'b0;
        @(negedge clk_i);
        assert (fflags_o == '0)
        else begin
            $display("Error: %0d ns: fflags %h after clear", $time, fflags_o);
            err_cnt++;
        end
        end_test("fflags clear");

        $display("Tests %0d, errors %0d, ops retired %0d", test_cnt, err_cnt, exp_retired);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: fp_pend.f
+incdir+rtl
rtl/fp_types_pkg.sv
rtl/fp_ctrl_pkg.sv
rtl/fp_issue_if.sv
rtl/fp_result_if.sv
rtl/fp_pend_queue.sv
rtl/fp_exec_unit.sv
rtl/fp_fflags_csr.sv
rtl/fp_pend_top.sv
bench/fp_pend_chk.sv
bench/fp_pend_tb.sv

// File: rtl/fp_ctrl_pkg.sv
`include "fp_pend_cfg.svh"

package fp_ctrl_pkg;

    // Supported operations
    typedef enum logic [2:0] {
        OP_FSGNJ,  // Copy b sign
        OP_FSGNJN, // Inverted b sign
        OP_FSGNJX, // Xor of signs
        OP_FMIN,
        OP_FMAX
    } fp_op_e;

    typedef logic [$clog2(`FP_PEND_ENTRIES)-1:0] ptr_t; // Head and tail
    typedef logic [$clog2(`FP_PEND_ENTRIES):0] num_t; // Occupancy, one bit wider

endpackage

// File: rtl/fp_exec_unit.sv
`timescale 1ns/10ps
`include "fp_pend_cfg.svh"

module fp_exec_unit (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      flush_i, // Kills min/max ops in flight
    fp_issue_if.sink  issue,
    fp_result_if.src  result
);
    import fp_types_pkg::*;
    import fp_ctrl_pkg::*;

    localparam fp32_t CANON_NAN = 32'h7fc00000;

    function automatic logic is_nan(input fp32_t x);
        is_nan = (x[30:23] == 8'hff) && (x[22:0] != '0);
    endfunction

    // Quiet bit clear on a NaN
    function automatic logic is_snan(input fp32_t x);
        is_snan = is_nan(x) && !x[22];
    endfunction

    function automatic fp32_t min_max(input fp32_t a, input fp32_t b, input logic is_max);
        logic a_lt_b;
        if (a[31] != b[31])
            a_lt_b = a[31];                 // Negative side lower, -0 below +0
        else if (a[31])
            a_lt_b = a[30:0] > b[30:0];     // Both negative, larger magnitude lower
        else
            a_lt_b = a[30:0] < b[30:0];
        if (is_nan(a) && is_nan(b))
            min_max = CANON_NAN;
        else if (is_nan(a))
            min_max = b;                    // Other operand wins
        else if (is_nan(b))
            min_max = a;
        else
            min_max = (a_lt_b ^ is_max) ? a : b;
    endfunction

    logic    fast_vld;
    tag_t    fast_tag;
    fp32_t   fast_res;
    logic    sgn;

    logic    slow_vld [`FP_SLOW_STAGES];
    tag_t    slow_tag [`FP_SLOW_STAGES];
    fp32_t   slow_res [`FP_SLOW_STAGES];
    fflags_t slow_flg [`FP_SLOW_STAGES];

    logic    is_slow;
    logic    is_fast;

    assign is_slow = (issue.op == OP_FMIN) || (issue.op == OP_FMAX);
    assign is_fast = !is_slow;

    // Injected sign, magnitude always from a
    always_comb begin
        case (issue.op)
            OP_FSGNJN: sgn = ~issue.b[31];
            OP_FSGNJX: sgn = issue.a[31] ^ issue.b[31];
            default:   sgn = issue.b[31];
        endcase
    end

    // Lane valids
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fast_vld <= 1'b0;
            for (int s = 0; s < `FP_SLOW_STAGES; s++) slow_vld[s] <= 1'b0;
        end else if (flush_i) begin
            fast_vld <= 1'b0;
            for (int s = 0; s < `FP_SLOW_STAGES; s++) slow_vld[s] <= 1'b0;
        end else begin
            fast_vld    <= issue.valid & is_fast;
            slow_vld[0] <= issue.valid & is_slow;
            for (int s = 1; s < `FP_SLOW_STAGES; s++) slow_vld[s] <= slow_vld[s-1];
        end
    end

    // Lane payload, result computed at stage 0 then carried
    always_ff @(posedge clk_i) begin
        fast_tag    <= issue.tag;
        fast_res    <= {sgn, issue.a[30:0]};
        slow_tag[0] <= issue.tag;
        slow_res[0] <= min_max(issue.a, issue.b, issue.op == OP_FMAX);
        slow_flg[0] <= {is_snan(issue.a) | is_snan(issue.b), 4'b0000}; // NV only
        for (int s = 1; s < `FP_SLOW_STAGES; s++) begin
            slow_tag[s] <= slow_tag[s-1];
            slow_res[s] <= slow_res[s-1];
            slow_flg[s] <= slow_flg[s-1];
        end
    end

    assign result.fast_valid = fast_vld;
    assign result.fast_tag   = fast_tag;
    assign result.fast_data  = fast_res;
    assign result.fast_flags = '0; // Sign injection never raises
    assign result.slow_valid = slow_vld[`FP_SLOW_STAGES-1];
    assign result.slow_tag   = slow_tag[`FP_SLOW_STAGES-1];
    assign result.slow_data  = slow_res[`FP_SLOW_STAGES-1];
    assign result.slow_flags = slow_flg[`FP_SLOW_STAGES-1];

endmodule

// File: rtl/fp_fflags_csr.sv
`timescale 1ns/10ps

module fp_fflags_csr (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      head_valid_i,   // Head entry done
    input  fp_types_pkg::fflags_t     head_flags_i,
    input  logic                      out_ready_i,
    input  logic                      fflags_clr_i,   // Clear sticky flags
    output logic                      advance_head_o, // Output handshake
    output fp_types_pkg::fflags_t     fflags_o,
    output fp_types_pkg::retire_cnt_t retired_o
);
    import fp_types_pkg::*;

    fflags_t     sticky;
    retire_cnt_t retire_cnt;

    // Retire on valid and ready
    assign advance_head_o = head_valid_i & out_ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sticky     <= '0;
            retire_cnt <= '0;
        end else begin
            if (fflags_clr_i)
                sticky <= advance_head_o ? head_flags_i : '0; // Same cycle retire survives
            else if (advance_head_o)
                sticky <= sticky | head_flags_i;
            if (advance_head_o)
                retire_cnt <= retire_cnt + retire_cnt_t'(1);
        end
    end

    assign fflags_o  = sticky;
    assign retired_o = retire_cnt;

endmodule

// File: rtl/fp_issue_if.sv
`timescale 1ns/10ps

interface fp_issue_if;
    import fp_types_pkg::*;
    import fp_ctrl_pkg::*;

    logic   valid; // High only in accept cycles
    fp_op_e op;
    fp32_t  a;
    fp32_t  b;
    tag_t   tag;   // Tag given by the queue

    // No ready, exec unit takes one op per cycle
    modport src  (output valid, op, a, b, tag);
    modport sink (input  valid, op, a, b, tag);

endinterface

// File: rtl/fp_pend_cfg.svh
`ifndef FP_PEND_CFG_SVH
`define FP_PEND_CFG_SVH

// Queue depth, entries in flight
`define FP_PEND_ENTRIES 8
// Tag space twice the depth, live tags never collide
`define FP_PEND_TAG_W 4
// Min/max lane depth
`define FP_SLOW_STAGES 3
`define FP_RETIRE_CNT_W 16 // Retire counter width

`endif

// File: rtl/fp_pend_queue.sv
`timescale 1ns/10ps
`include "fp_pend_cfg.svh"

module fp_pend_queue (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,        // Drop all entries
    input  logic                 in_valid_i,
    input  fp_ctrl_pkg::fp_op_e  in_op_i,
    input  fp_types_pkg::fp32_t  in_a_i,
    input  fp_types_pkg::fp32_t  in_b_i,
    output logic                 in_ready_o,
    output fp_types_pkg::tag_t   in_tag_o,       // Tag of the next accepted op
    fp_issue_if.src              issue,
    fp_result_if.sink            result,
    input  logic                 advance_head_i, // Head retires this cycle
    output logic                 head_valid_o,
    output fp_types_pkg::tag_t   head_tag_o,
    output fp_types_pkg::fp32_t  head_data_o,
    output fp_types_pkg::fflags_t head_flags_o
);
    import fp_types_pkg::*;
    import fp_ctrl_pkg::*;

    localparam num_t MAX_NUM = `FP_PEND_ENTRIES;

    // Entry tables, payload only
    tag_t    tag_tbl  [`FP_PEND_ENTRIES];
    fp32_t   data_tbl [`FP_PEND_ENTRIES];
    fflags_t flag_tbl [`FP_PEND_ENTRIES];
    logic    done_tbl [`FP_PEND_ENTRIES]; // Result written back

    ptr_t head;    // Oldest entry
    ptr_t tail;    // Next free entry
    num_t num;     // Entries in use
    tag_t tag_cnt; // Low bits track tail

    logic write_en;
    logic advance_en;

    // Full means all entries used, no early margin
    assign in_ready_o = (num < MAX_NUM) & rstn_i & ~flush_i;
    assign write_en   = in_valid_i & in_ready_o;
    assign advance_en = advance_head_i & (num != '0); // Never pop an empty queue
    assign in_tag_o   = tag_cnt;

    // Forward accepted op to the lanes in the same cycle
    assign issue.valid = write_en;
    assign issue.op    = in_op_i;
    assign issue.a     = in_a_i;
    assign issue.b     = in_b_i;
    assign issue.tag   = tag_cnt;

    always_ff @(posedge clk_i) begin
        if (write_en) begin
            tag_tbl[tail]  <= tag_cnt;
            done_tbl[tail] <= 1'b0; // Waits for its lane
        end
        // Both lanes may finish together, each hits its own entry
        for (int j = 0; j < `FP_PEND_ENTRIES; j++) begin
            if (result.fast_valid && (tag_tbl[j] == result.fast_tag)) begin
                done_tbl[j] <= 1'b1;
                data_tbl[j] <= result.fast_data;
                flag_tbl[j] <= result.fast_flags;
            end
            if (result.slow_valid && (tag_tbl[j] == result.slow_tag)) begin
                done_tbl[j] <= 1'b1;
                data_tbl[j] <= result.slow_data;
                flag_tbl[j] <= result.slow_flags;
            end
        end
    end

    // Pointers and tag counter
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head    <= '0;
            tail    <= '0;
            num     <= '0;
            tag_cnt <= '0;
        end else if (flush_i) begin
            head    <= '0; // Tags restart at zero
            tail    <= '0;
            num     <= '0;
            tag_cnt <= '0;
        end else begin
            head    <= head + ptr_t'(advance_en);
            tail    <= tail + ptr_t'(write_en);
            num     <= num + num_t'(write_en) - num_t'(advance_en); // Accept and retire cancel
            tag_cnt <= tag_cnt + tag_t'(write_en);
        end
    end

    // Head shown only once done, stable until popped
    assign head_valid_o = (num != '0) & done_tbl[head];
    assign head_tag_o   = head_valid_o ? tag_tbl[head]  : '0;
    assign head_data_o  = head_valid_o ? data_tbl[head] : '0;
    assign head_flags_o = head_valid_o ? flag_tbl[head] : '0;

endmodule

// File: rtl/fp_pend_top.sv
`timescale 1ns/10ps

module fp_pend_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,

    // Issue side
    input  logic                      in_valid_i,
    input  fp_ctrl_pkg::fp_op_e       in_op_i,
    input  fp_types_pkg::fp32_t       in_a_i,
    input  fp_types_pkg::fp32_t       in_b_i,
    output logic                      in_ready_o,
    output fp_types_pkg::tag_t        in_tag_o,

    // Retire side
    input  logic                      out_ready_i,
    output logic                      out_valid_o,
    output fp_types_pkg::tag_t        out_tag_o,
    output fp_types_pkg::fp32_t       out_data_o,
    output fp_types_pkg::fflags_t     out_flags_o,

    // Flags and count
    input  logic                      fflags_clr_i,
    output fp_types_pkg::fflags_t     fflags_o,
    output fp_types_pkg::retire_cnt_t retired_o
);

    logic advance_head; // From the output handshake

    fp_issue_if  issue_bus ();
    fp_result_if result_bus ();

    fp_pend_queue u_queue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .in_valid_i     (in_valid_i),
        .in_op_i        (in_op_i),
        .in_a_i         (in_a_i),
        .in_b_i         (in_b_i),
        .in_ready_o     (in_ready_o),
        .in_tag_o       (in_tag_o),
        .issue          (issue_bus.src),
        .result         (result_bus.sink),
        .advance_head_i (advance_head),
        .head_valid_o   (out_valid_o), // Head drives the output port directly
        .head_tag_o     (out_tag_o),
        .head_data_o    (out_data_o),
        .head_flags_o   (out_flags_o)
    );

    fp_exec_unit u_exec (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .issue   (issue_bus.sink),
        .result  (result_bus.src)
    );

    fp_fflags_csr u_csr (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .head_valid_i   (out_valid_o),
        .head_flags_i   (out_flags_o),
        .out_ready_i    (out_ready_i),
        .fflags_clr_i   (fflags_clr_i),
        .advance_head_o (advance_head),
        .fflags_o       (fflags_o),
        .retired_o      (retired_o)
    );

endmodule

// File: rtl/fp_result_if.sv
`timescale 1ns/10ps

interface fp_result_if;
    import fp_types_pkg::*;

    // Sign injection lane
    logic    fast_valid;
    tag_t    fast_tag;
    fp32_t   fast_data;
    fflags_t fast_flags;

    // Min/max lane
    logic    slow_valid;
    tag_t    slow_tag;
    fp32_t   slow_data;
    fflags_t slow_flags;

    modport src  (output fast_valid, fast_tag, fast_data, fast_flags,
                  output slow_valid, slow_tag, slow_data, slow_flags);
    modport sink (input  fast_valid, fast_tag, fast_data, fast_flags,
                  input  slow_valid, slow_tag, slow_data, slow_flags);

endinterface

// File: rtl/fp_types_pkg.sv
`include "fp_pend_cfg.svh"

package fp_types_pkg;

    // Single precision operand or result
    typedef logic [31:0] fp32_t;

    // Exception flags, NV DZ OF UF NX from msb down
    typedef logic [4:0] fflags_t;

    typedef logic [`FP_PEND_TAG_W-1:0] tag_t; // Op tag, wraps
    typedef logic [`FP_RETIRE_CNT_W-1:0] retire_cnt_t; // Retired op count

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f fp_pend.f --top-module fp_pend_tb -o fp_pend_sim &&
    ./obj_dir/fp_pend_sim | tee sim.log ||
    { echo "Build or run failed"; exit 1; }

grep -qx "=== PASS ===" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see sim.log"; exit 1; }
